/* common/lc3b_params.svh */
`ifndef LC3B_PARAMS_SVH
`define LC3B_PARAMS_SVH

// Program counter loaded while reset is held
`define LC3B_RESET_PC 16'h0000

// BR with no condition bits set, placed in empty and squashed slots
`define LC3B_NOP_WORD 16'h0000

`endif

/* common/lc3b_types.sv */
package lc3b_types;

    typedef logic [15:0] lc3b_word;
    typedef logic [2:0] lc3b_reg;
    typedef logic [2:0] lc3b_nzp;

    // Only the opcodes this datapath executes, the rest decode as no-ops
    typedef enum logic [3:0] {
        op_br  = 4'b0000,
        op_add = 4'b0001,
        op_and = 4'b0101,
        op_ldr = 4'b0110,
        op_str = 4'b0111,
        op_not = 4'b1001
    } lc3b_opcode;

    typedef enum logic [1:0] {
        alu_add,
        alu_and,
        alu_not,
        alu_pass
    } lc3b_aluop;

    // An all-zero word is a harmless no-op
    typedef struct packed {
        lc3b_opcode opcode;
        lc3b_aluop aluop;
        logic use_imm;
        logic load_regfile;
        logic load_cc;
        logic mem_read;
        logic mem_write;
        logic is_branch;
    } lc3b_control_word;

endpackage : lc3b_types

/* common/pipe_if.sv */
`timescale 1ns/10ps

// One pipeline slot, driven by the registers at the end of a stage
interface pipe_if;
    import lc3b_types::*;

    logic valid;
    lc3b_control_word ctrl;
    lc3b_word pc;
    lc3b_word instruction;
    lc3b_reg dest;
    lc3b_word src1_data;
    lc3b_word src2_data;
    // Computed value, loaded word, or the store data of an STR
    lc3b_word result;

    modport out (
        output valid,
        output ctrl,
        output pc,
        output instruction,
        output dest,
        output src1_data,
        output src2_data,
        output result
    );

    modport in (
        input valid,
        input ctrl,
        input pc,
        input instruction,
        input dest,
        input src1_data,
        input src2_data,
        input result
    );

endinterface : pipe_if

/* fetch/if_stage.sv */
`timescale 1ns/10ps
`include "lc3b_params.svh"

module if_stage (
    input logic clk,
    input logic reset,
    input logic stall,
    input logic br_taken,
    input lc3b_types::lc3b_word br_target,
    input logic resp_a,
    input lc3b_types::lc3b_word rdata_a,
    output logic read_a,
    output lc3b_types::lc3b_word address_a,
    output logic held,
    pipe_if.out fetch_slot
);
    import lc3b_types::*;

    lc3b_word pc;
    lc3b_word held_word;
    lc3b_word fetched;
    logic fetch_en;
    logic word_ready;

    // Port A stays idle until the first edge that sees reset released
    assign read_a = fetch_en && !held;
    assign address_a = pc;
    assign word_ready = held || (read_a && resp_a);
    assign fetched = held ? held_word : rdata_a;

    always_ff @(posedge clk) begin
        if (reset) begin
            fetch_en <= 1'b0;
            pc <= `LC3B_RESET_PC;
            held <= 1'b0;
            fetch_slot.valid <= 1'b0;
        end else begin
            fetch_en <= 1'b1;
            if (!stall) begin
                held <= 1'b0;
                if (br_taken) begin
                    // The word fetched this cycle is on the wrong path
                    pc <= br_target;
                    fetch_slot.valid <= 1'b0;
                end else if (word_ready) begin
                    pc <= pc + 16'd2;
                    fetch_slot.valid <= 1'b1;
                end else begin
                    fetch_slot.valid <= 1'b0;
                end
            end else if (read_a && resp_a) begin
                held <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            fetch_slot.pc <= pc;
            if (br_taken || !word_ready)
                fetch_slot.instruction <= `LC3B_NOP_WORD;
            else
                fetch_slot.instruction <= fetched;
        end
        // Keep the word that arrived while another port holds the pipeline
        if (stall && read_a && resp_a)
            held_word <= rdata_a;
    end

    // Fields filled in by decode
    assign fetch_slot.ctrl = '0;
    assign fetch_slot.dest = fetch_slot.instruction[11:9];
    assign fetch_slot.src1_data = '0;
    assign fetch_slot.src2_data = '0;
    assign fetch_slot.result = '0;

    a_fetch_addr_stable: assert property (@(posedge clk) disable iff (reset)
        read_a && !resp_a |=> read_a && $stable(address_a));

endmodule : if_stage

/* decode/id_stage.sv */
`timescale 1ns/10ps
`include "lc3b_params.svh"

module id_stage (
    input logic clk,
    input logic reset,
    input logic stall,
    input logic squash,
    input logic wb_en,
    input lc3b_types::lc3b_reg wb_dest,
    input lc3b_types::lc3b_word wb_data,
    pipe_if.in in_slot,
    pipe_if.out out_slot
);
    import lc3b_types::*;

    lc3b_word regs [8];
    lc3b_word instr;
    lc3b_control_word ctrl;
    lc3b_word sr1_data;
    lc3b_word sr2_data;
    lc3b_word store_data;
    lc3b_word imm5_sext;
    lc3b_word offset6_sext;
    lc3b_word src2_sel;
    logic kill;

    assign instr = in_slot.instruction;
    assign kill = squash || !in_slot.valid;

    always_comb begin
        ctrl = '0;
        ctrl.aluop = alu_pass;
        case (lc3b_opcode'(instr[15:12]))
            op_add, op_and: begin
                ctrl.opcode = lc3b_opcode'(instr[15:12]);
                ctrl.aluop = (instr[15:12] == op_add) ? alu_add : alu_and;
                ctrl.use_imm = instr[5];
                ctrl.load_regfile = 1'b1;
                ctrl.load_cc = 1'b1;
            end
            op_not: begin
                ctrl.opcode = op_not;
                ctrl.aluop = alu_not;
                ctrl.load_regfile = 1'b1;
                ctrl.load_cc = 1'b1;
            end
            op_ldr: begin
                ctrl.opcode = op_ldr;
                ctrl.aluop = alu_add;
                ctrl.use_imm = 1'b1;
                ctrl.mem_read = 1'b1;
                ctrl.load_regfile = 1'b1;
                ctrl.load_cc = 1'b1;
            end
            op_str: begin
                ctrl.opcode = op_str;
                ctrl.aluop = alu_add;
                ctrl.use_imm = 1'b1;
                ctrl.mem_write = 1'b1;
            end
            op_br: begin
                ctrl.opcode = op_br;
                ctrl.is_branch = 1'b1;
            end
            default: ;
        endcase
    end

    // Reads see a writeback in the same cycle
    assign sr1_data = (wb_en && wb_dest == instr[8:6]) ? wb_data : regs[instr[8:6]];
    assign sr2_data = (wb_en && wb_dest == instr[2:0]) ? wb_data : regs[instr[2:0]];
    assign store_data = (wb_en && wb_dest == instr[11:9]) ? wb_data : regs[instr[11:9]];

    assign imm5_sext = {{11{instr[4]}}, instr[4:0]};
    assign offset6_sext = {{10{instr[5]}}, instr[5:0]};

    always_comb begin
        if (!ctrl.use_imm)
            src2_sel = sr2_data;
        else if (ctrl.mem_read || ctrl.mem_write)
            src2_sel = offset6_sext;
        else
            src2_sel = imm5_sext;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 8; i++)
                regs[i] <= '0;
        end else if (wb_en) begin
            regs[wb_dest] <= wb_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out_slot.valid <= 1'b0;
            out_slot.ctrl <= '0;
        end else if (!stall) begin
            out_slot.valid <= !kill;
            out_slot.ctrl <= kill ? '0 : ctrl;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            out_slot.instruction <= kill ? `LC3B_NOP_WORD : instr;
            out_slot.pc <= in_slot.pc;
            out_slot.dest <= instr[11:9];
            out_slot.src1_data <= sr1_data;
            out_slot.src2_data <= src2_sel;
            out_slot.result <= store_data;
        end
    end

endmodule : id_stage

/* execute/ex_stage.sv */
`timescale 1ns/10ps

module ex_stage (
    input logic clk,
    input logic reset,
    input logic stall,
    input lc3b_types::lc3b_nzp cc,
    pipe_if.in in_slot,
    pipe_if.out out_slot,
    output logic br_taken,
    output lc3b_types::lc3b_word br_target
);
    import lc3b_types::*;

    lc3b_word alu_b;
    lc3b_word alu_out;
    lc3b_word offset9_sext;
    logic is_mem;

    assign is_mem = in_slot.ctrl.mem_read || in_slot.ctrl.mem_write;

    // Offsets of LDR and STR count words
    assign alu_b = is_mem ? {in_slot.src2_data[14:0], 1'b0} : in_slot.src2_data;

    always_comb begin
        case (in_slot.ctrl.aluop)
            alu_add: alu_out = in_slot.src1_data + alu_b;
            alu_and: alu_out = in_slot.src1_data & alu_b;
            alu_not: alu_out = ~in_slot.src1_data;
            alu_pass: alu_out = in_slot.src1_data;
        endcase
    end

    assign offset9_sext = {{7{in_slot.instruction[8]}}, in_slot.instruction[8:0]};
    assign br_target = in_slot.pc + 16'd2 + {offset9_sext[14:0], 1'b0};

    // Decode clears the control word of every invalid slot
    assign br_taken = in_slot.ctrl.is_branch && |(in_slot.instruction[11:9] & cc);

    always_ff @(posedge clk) begin
        if (reset) begin
            out_slot.valid <= 1'b0;
            out_slot.ctrl <= '0;
        end else if (!stall) begin
            out_slot.valid <= in_slot.valid;
            out_slot.ctrl <= in_slot.ctrl;
        end
    end

    // The effective address moves on in src1_data and STR data stays in result
    always_ff @(posedge clk) begin
        if (!stall) begin
            out_slot.pc <= in_slot.pc;
            out_slot.instruction <= in_slot.instruction;
            out_slot.dest <= in_slot.dest;
            out_slot.src1_data <= alu_out;
            out_slot.src2_data <= in_slot.src2_data;
            out_slot.result <= in_slot.ctrl.mem_write ? in_slot.result : alu_out;
        end
    end

    a_branch_valid: assert property (@(posedge clk) disable iff (reset)
        br_taken |-> in_slot.valid);

    // Decode squashes the instruction right behind a taken branch
    a_branch_squash: assert property (@(posedge clk) disable iff (reset)
        br_taken && !stall |=> !in_slot.valid);

endmodule : ex_stage

/* logic/mem_wb_stage.sv */
`timescale 1ns/10ps

module mem_wb_stage (
    input logic clk,
    input logic reset,
    input logic stall,
    pipe_if.in in_slot,
    pipe_if.out out_slot,
    input logic resp_b,
    input lc3b_types::lc3b_word rdata_b,
    output logic read_b,
    output logic write_b,
    output lc3b_types::lc3b_word address_b,
    output lc3b_types::lc3b_word wdata_b,
    output logic [1:0] wmask_b,
    output logic wb_en,
    output lc3b_types::lc3b_reg wb_dest,
    output lc3b_types::lc3b_word wb_data,
    output lc3b_types::lc3b_nzp cc
);
    import lc3b_types::*;

    logic mem_done;
    lc3b_word held_rdata;
    lc3b_word load_data;
    lc3b_nzp cc_reg;
    lc3b_nzp new_cc;
    logic cc_en;

    // An access that finished while fetch still waits is not issued again
    assign read_b = in_slot.valid && in_slot.ctrl.mem_read && !mem_done;
    assign write_b = in_slot.valid && in_slot.ctrl.mem_write && !mem_done;
    assign address_b = in_slot.src1_data;
    assign wdata_b = in_slot.result;
    assign wmask_b = 2'b11;
    assign load_data = mem_done ? held_rdata : rdata_b;

    always_ff @(posedge clk) begin
        if (reset) begin
            mem_done <= 1'b0;
            out_slot.valid <= 1'b0;
            out_slot.ctrl <= '0;
        end else if (!stall) begin
            mem_done <= 1'b0;
            out_slot.valid <= in_slot.valid;
            out_slot.ctrl <= in_slot.ctrl;
        end else if ((read_b || write_b) && resp_b) begin
            mem_done <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            out_slot.pc <= in_slot.pc;
            out_slot.instruction <= in_slot.instruction;
            out_slot.dest <= in_slot.dest;
            out_slot.src1_data <= in_slot.src1_data;
            out_slot.src2_data <= in_slot.src2_data;
            out_slot.result <= in_slot.ctrl.mem_read ? load_data : in_slot.result;
        end
        if (stall && read_b && resp_b)
            held_rdata <= rdata_b;
    end

    assign wb_en = out_slot.valid && out_slot.ctrl.load_regfile;
    assign wb_dest = out_slot.dest;
    assign wb_data = out_slot.result;

    always_comb begin
        if (out_slot.result[15])
            new_cc = 3'b100;
        else if (out_slot.result == '0)
            new_cc = 3'b010;
        else
            new_cc = 3'b001;
    end

    assign cc_en = out_slot.valid && out_slot.ctrl.load_cc;

    // Branches in execute see the new code in the same cycle
    assign cc = cc_en ? new_cc : cc_reg;

    always_ff @(posedge clk) begin
        if (reset)
            cc_reg <= 3'b010;
        else if (cc_en)
            cc_reg <= new_cc;
    end

    a_port_b_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(read_b && write_b));

    a_port_b_aligned: assert property (@(posedge clk) disable iff (reset)
        (read_b || write_b) |-> !address_b[0]);

endmodule : mem_wb_stage

/* logic/cpu_datapath.sv */
`timescale 1ns/10ps

module cpu_datapath (
    input logic clk,
    input logic reset,

    // Port A, instruction fetch
    input logic resp_a,
    input lc3b_types::lc3b_word rdata_a,
    output logic read_a,
    output logic write_a,
    output logic [1:0] wmask_a,
    output lc3b_types::lc3b_word address_a,
    output lc3b_types::lc3b_word wdata_a,

    // Port B, loads and stores
    input logic resp_b,
    input lc3b_types::lc3b_word rdata_b,
    output logic read_b,
    output logic write_b,
    output logic [1:0] wmask_b,
    output lc3b_types::lc3b_word address_b,
    output lc3b_types::lc3b_word wdata_b
);
    import lc3b_types::*;

    logic stall;
    logic held_a;
    logic br_taken;
    lc3b_word br_target;
    logic wb_en;
    lc3b_reg wb_dest;
    lc3b_word wb_data;
    lc3b_nzp cc;

    pipe_if if_id ();
    pipe_if id_ex ();
    pipe_if ex_mem ();
    pipe_if mem_wb ();

    // Port A only reads
    assign write_a = 1'b0;
    assign wmask_a = 2'b11;
    assign wdata_a = '0;

    // Any port still waiting freezes every stage
    assign stall = (read_a && !resp_a && !held_a) ||
                   (read_b && !resp_b) ||
                   (write_b && !resp_b);

    if_stage fetch (
        .clk(clk),
        .reset(reset),
        .stall(stall),
        .br_taken(br_taken),
        .br_target(br_target),
        .resp_a(resp_a),
        .rdata_a(rdata_a),
        .read_a(read_a),
        .address_a(address_a),
        .held(held_a),
        .fetch_slot(if_id)
    );

    id_stage decode (
        .clk(clk),
        .reset(reset),
        .stall(stall),
        .squash(br_taken),
        .wb_en(wb_en),
        .wb_dest(wb_dest),
        .wb_data(wb_data),
        .in_slot(if_id),
        .out_slot(id_ex)
    );

    ex_stage execute (
        .clk(clk),
        .reset(reset),
        .stall(stall),
        .cc(cc),
        .in_slot(id_ex),
        .out_slot(ex_mem),
        .br_taken(br_taken),
        .br_target(br_target)
    );

    mem_wb_stage mem_wb_unit (
        .clk(clk),
        .reset(reset),
        .stall(stall),
        .in_slot(ex_mem),
        .out_slot(mem_wb),
        .resp_b(resp_b),
        .rdata_b(rdata_b),
        .read_b(read_b),
        .write_b(write_b),
        .address_b(address_b),
        .wdata_b(wdata_b),
        .wmask_b(wmask_b),
        .wb_en(wb_en),
        .wb_dest(wb_dest),
        .wb_data(wb_data),
        .cc(cc)
    );

endmodule : cpu_datapath

/* testbench/lc3b_mem_model.sv */
`timescale 1ns/10ps
`include "lc3b_params.svh"

// Word memory behind both CPU ports, the array repeats every 1 KB of address space
module lc3b_mem_model (
    input logic clk,
    input logic reset,
    input logic latency_on,
    input logic read_a,
    input logic [15:0] address_a,
    output logic resp_a,
    output logic [15:0] rdata_a,
    input logic read_b,
    input logic write_b,
    input logic [15:0] address_b,
    input logic [15:0] wdata_b,
    output logic resp_b,
    output logic [15:0] rdata_b
);
    logic [15:0] words [512];
    logic [15:0] log_addr [64];
    logic [15:0] log_data [64];
    int log_count;
    logic [31:0] rng_state;
    int wait_a;
    int wait_b;
    logic busy_a;
    logic busy_b;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Extra wait cycles for a new access, 0 to 3 when latency is on
    task draw_latency(output int cycles);
        if (latency_on) begin
            rng_state = xorshift(rng_state);
            cycles = rng_state[1:0];
        end else begin
            cycles = 0;
        end
    endtask

    task clear;
        for (int i = 0; i < 512; i++)
            words[i] = `LC3B_NOP_WORD;
    endtask

    task poke(input logic [15:0] addr, input logic [15:0] data);
        words[addr[9:1]] = data;
    endtask

    initial begin
        rng_state = 32'h2f3d5c31;
        log_count = 0;
        busy_a = 1'b0;
        busy_b = 1'b0;
        resp_a = 1'b0;
        resp_b = 1'b0;
        rdata_a = '0;
        rdata_b = '0;
    end

    // Responses change on the falling edge and are seen by the CPU on the next rising one
    always @(negedge clk) begin
        if (reset) begin
            resp_a = 1'b0;
            resp_b = 1'b0;
            busy_a = 1'b0;
            busy_b = 1'b0;
            log_count = 0;
        end else begin
            resp_a = 1'b0;
            resp_b = 1'b0;
            if (read_a) begin
                if (!busy_a) begin
                    draw_latency(wait_a);
                    busy_a = 1'b1;
                end
                if (wait_a == 0) begin
                    resp_a = 1'b1;
                    rdata_a = words[address_a[9:1]];
                    busy_a = 1'b0;
                end else begin
                    wait_a--;
                end
            end else begin
                busy_a = 1'b0;
            end
            if (read_b || write_b) begin
                if (!busy_b) begin
                    draw_latency(wait_b);
                    busy_b = 1'b1;
                end
                if (wait_b == 0) begin
                    resp_b = 1'b1;
                    busy_b = 1'b0;
                    if (write_b) begin
                        words[address_b[9:1]] = wdata_b;
                        if (log_count < 64) begin
                            log_addr[log_count] = address_b;
                            log_data[log_count] = wdata_b;
                            log_count++;
                        end
                    end else begin
                        rdata_b = words[address_b[9:1]];
                    end
                end else begin
                    wait_b--;
                end
            end else begin
                busy_b = 1'b0;
            end
        end
    end

endmodule : lc3b_mem_model

/* testbench/cpu_datapath_tb.sv */
`timescale 1ns/10ps
`include "lc3b_params.svh"

module cpu_datapath_tb;
    import lc3b_types::*;

    localparam int cycle_limit = 4000;
    // Every program ends with a store here
    localparam lc3b_word done_addr = 16'hFFFE;

    // LC-3b opcodes
    localparam logic [3:0] add_op = 4'b0001;
    localparam logic [3:0] and_op = 4'b0101;
    localparam logic [3:0] ldr_op = 4'b0110;
    localparam logic [3:0] str_op = 4'b0111;

    logic clk;
    logic reset;
    logic latency_on;
    logic resp_a;
    lc3b_word rdata_a;
    logic read_a;
    logic write_a;
    logic [1:0] wmask_a;
    lc3b_word address_a;
    lc3b_word wdata_a;
    logic resp_b;
    lc3b_word rdata_b;
    logic read_b;
    logic write_b;
    logic [1:0] wmask_b;
    lc3b_word address_b;
    lc3b_word wdata_b;

    int cycles = 0;
    int prog_len;
    lc3b_word exp_addr [32];
    lc3b_word exp_data [32];
    int exp_count;
    lc3b_word saved_addr [32];
    lc3b_word saved_data [32];
    int saved_count;

    cpu_datapath dut (
        .clk(clk),
        .reset(reset),
        .resp_a(resp_a),
        .rdata_a(rdata_a),
        .read_a(read_a),
        .write_a(write_a),
        .wmask_a(wmask_a),
        .address_a(address_a),
        .wdata_a(wdata_a),
        .resp_b(resp_b),
        .rdata_b(rdata_b),
        .read_b(read_b),
        .write_b(write_b),
        .wmask_b(wmask_b),
        .address_b(address_b),
        .wdata_b(wdata_b)
    );

    lc3b_mem_model mem (
        .clk(clk),
        .reset(reset),
        .latency_on(latency_on),
        .read_a(read_a),
        .address_a(address_a),
        .resp_a(resp_a),
        .rdata_a(rdata_a),
        .read_b(read_b),
        .write_b(write_b),
        .address_b(address_b),
        .wdata_b(wdata_b),
        .resp_b(resp_b),
        .rdata_b(rdata_b)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("Timeout: no final store within %0d cycles", cycle_limit);
            $display("Simulation FAILED");
            $fatal(1);
        end
    end

    function automatic lc3b_word alu_rr(input logic [3:0] op, input lc3b_reg dr,
                                        input lc3b_reg sr1, input lc3b_reg sr2);
        return {op, dr, sr1, 3'b000, sr2};
    endfunction

    function automatic lc3b_word alu_ri(input logic [3:0] op, input lc3b_reg dr,
                                        input lc3b_reg sr1, input int imm);
        return {op, dr, sr1, 1'b1, imm[4:0]};
    endfunction

    function automatic lc3b_word not_op(input lc3b_reg dr, input lc3b_reg sr);
        return {4'b1001, dr, sr, 6'b111111};
    endfunction

    function automatic lc3b_word mem_op(input logic [3:0] op, input lc3b_reg r,
                                        input lc3b_reg base, input int off);
        return {op, r, base, off[5:0]};
    endfunction

    function automatic lc3b_word br_op(input logic [2:0] nzp, input int off);
        return {4'b0000, nzp, off[8:0]};
    endfunction

    // Byte displacement of a word offset
    function automatic lc3b_word word_offset(input int off);
        return lc3b_word'(off * 2);
    endfunction

    task automatic check(input string name, input lc3b_word expected, input lc3b_word actual);
        if (actual !== expected) begin
            $display("FAIL %s: expected %h, actual %h", name, expected, actual);
            $display("Simulation FAILED");
            $fatal(1);
        end
    endtask

    // Port A never writes and port B always writes whole words
    always @(negedge clk) begin
        check("port A write_a", 16'h0000, write_a);
        check("port A wmask_a", 16'h0003, wmask_a);
        check("port A wdata_a", 16'h0000, wdata_a);
        check("port B wmask_b", 16'h0003, wmask_b);
    end

    task emit(input lc3b_word w);
        mem.poke(lc3b_word'(prog_len * 2), w);
        prog_len++;
    endtask

    // Two no-ops keep a consumer three slots behind its producer
    task gap;
        emit(`LC3B_NOP_WORD);
        emit(`LC3B_NOP_WORD);
    endtask

    task expect_store(input lc3b_word addr, input lc3b_word data);
        exp_addr[exp_count] = addr;
        exp_data[exp_count] = data;
        exp_count++;
    endtask

    // The CPU sits in reset while the memory is reloaded
    task begin_program(input logic slow);
        @(negedge clk);
        reset <= 1'b1;
        latency_on <= slow;
        @(posedge clk);
        mem.clear();
        prog_len = 0;
        exp_count = 0;
    endtask

    task release_reset;
        repeat (2) begin
            @(negedge clk);
            check("reset read_a", 16'h0000, read_a);
            check("reset read_b", 16'h0000, read_b);
            check("reset write_b", 16'h0000, write_b);
        end
        reset <= 1'b0;
    endtask

    task wait_for_done;
        @(posedge clk);
        while (!(mem.log_count > 0 && mem.log_addr[mem.log_count - 1] == done_addr))
            @(posedge clk);
    endtask

    task compare_log(input string name);
        check({name, " store count"}, lc3b_word'(exp_count), lc3b_word'(mem.log_count));
        for (int i = 0; i < exp_count; i++) begin
            check($sformatf("%s store %0d address", name, i), exp_addr[i], mem.log_addr[i]);
            check($sformatf("%s store %0d data", name, i), exp_data[i], mem.log_data[i]);
        end
    endtask

    task reset_behavior;
        begin_program(1'b0);
        emit(mem_op(str_op, 0, 0, -1));
        expect_store(done_addr, 16'h0000);
        release_reset();
        @(negedge clk);
        check("reset idle read_b", 16'h0000, read_b);
        check("reset idle write_b", 16'h0000, write_b);
        check("reset first read_a", 16'h0001, read_a);
        check("reset first fetch address", 16'h0000, address_a);
        wait_for_done();
        compare_log("reset");
    endtask

    // With slow set the same program runs under random latency on both ports
    task arith_program(input logic slow);
        string name;
        lc3b_word a;
        lc3b_word b;
        name = slow ? "backpressure" : "arith";
        a = 16'd7;
        b = 16'hFFFD;
        begin_program(slow);
        emit(alu_ri(add_op, 1, 0, 7));
        emit(alu_ri(add_op, 2, 0, -3));
        gap();
        emit(alu_rr(add_op, 3, 1, 2));
        emit(alu_rr(and_op, 4, 1, 2));
        emit(alu_ri(and_op, 5, 2, 14));
        emit(not_op(6, 1));
        gap();
        emit(mem_op(str_op, 3, 0, -32));
        emit(mem_op(str_op, 4, 0, -31));
        emit(mem_op(str_op, 5, 0, -30));
        emit(mem_op(str_op, 6, 0, -29));
        emit(mem_op(str_op, 1, 0, -1));
        // R0 stays zero so each address is the offset alone
        expect_store(word_offset(-32), a + b);
        expect_store(word_offset(-31), a & b);
        expect_store(word_offset(-30), b & 16'h000E);
        expect_store(word_offset(-29), ~a);
        expect_store(done_addr, a);
        release_reset();
        wait_for_done();
        compare_log(name);
        if (slow) begin
            check({name, " log length"}, lc3b_word'(saved_count), lc3b_word'(mem.log_count));
            for (int i = 0; i < saved_count; i++) begin
                check($sformatf("%s log %0d address", name, i), saved_addr[i], mem.log_addr[i]);
                check($sformatf("%s log %0d data", name, i), saved_data[i], mem.log_data[i]);
            end
        end else begin
            saved_count = mem.log_count;
            for (int i = 0; i < saved_count; i++) begin
                saved_addr[i] = mem.log_addr[i];
                saved_data[i] = mem.log_data[i];
            end
        end
    endtask

    task load_store_program;
        lc3b_word base;
        lc3b_word pos;
        lc3b_word neg;
        base = 16'hFFE0;
        pos = 16'h1234;
        neg = 16'h8421;
        begin_program(1'b0);
        mem.poke(word_offset(-32), base);
        mem.poke(base + word_offset(4), pos);
        mem.poke(base + word_offset(-4), neg);
        emit(mem_op(ldr_op, 1, 0, -32));
        gap();
        emit(mem_op(ldr_op, 2, 1, 4));
        emit(mem_op(ldr_op, 3, 1, -4));
        gap();
        emit(mem_op(str_op, 2, 1, 10));
        emit(mem_op(str_op, 3, 1, -12));
        emit(mem_op(str_op, 1, 0, -1));
        expect_store(base + word_offset(10), pos);
        expect_store(base + word_offset(-12), neg);
        expect_store(done_addr, base);
        release_reset();
        wait_for_done();
        compare_log("load_store");
    endtask

    // Stores right behind a taken branch are on the wrong path and must not reach memory
    task branch_program;
        lc3b_word r1;
        lc3b_word r3;
        r1 = 16'd5;
        r3 = ~r1;
        begin_program(1'b0);
        emit(alu_ri(add_op, 1, 0, 5));
        gap();
        emit(br_op(3'b100, 2));
        emit(br_op(3'b001, 2));
        emit(mem_op(str_op, 1, 0, -20));
        emit(mem_op(str_op, 1, 0, -19));
        emit(mem_op(str_op, 1, 0, -18));
        emit(alu_ri(and_op, 2, 1, 0));
        gap();
        emit(br_op(3'b010, 2));
        emit(mem_op(str_op, 1, 0, -17));
        emit(mem_op(str_op, 1, 0, -16));
        emit(mem_op(str_op, 1, 0, -15));
        emit(not_op(3, 1));
        gap();
        emit(br_op(3'b011, 2));
        emit(mem_op(str_op, 3, 0, -14));
        emit(br_op(3'b100, 2));
        emit(mem_op(str_op, 3, 0, -12));
        emit(mem_op(str_op, 3, 0, -11));
        emit(mem_op(str_op, 3, 0, -13));
        emit(mem_op(str_op, 0, 0, -1));
        expect_store(word_offset(-18), r1);
        expect_store(word_offset(-15), r1);
        expect_store(word_offset(-14), r3);
        expect_store(word_offset(-13), r3);
        expect_store(done_addr, 16'h0000);
        release_reset();
        wait_for_done();
        compare_log("branches");
    endtask

    initial begin
        reset = 1'b1;
        latency_on = 1'b0;
        saved_count = 0;
        reset_behavior();
        arith_program(1'b0);
        load_store_program();
        branch_program();
        arith_program(1'b1);
        $display("Simulation PASSED");
        $finish;
    end

endmodule : cpu_datapath_tb

/* cpu_datapath.f */
+incdir+common
common/lc3b_types.sv
common/pipe_if.sv
fetch/if_stage.sv
decode/id_stage.sv
execute/ex_stage.sv
logic/mem_wb_stage.sv
logic/cpu_datapath.sv
testbench/lc3b_mem_model.sv
testbench/cpu_datapath_tb.sv
